/* hw/JZJCoreF_defs.svh */
`ifndef JZJCOREF_DEFS_SVH
`define JZJCOREF_DEFS_SVH

`define MEMORY_WORDS 4096//Unified memory depth in 32-bit words
`define RESET_PC 32'h00000000//First fetch address
`define REGISTER_COUNT 32

`endif

/* hw/JZJCoreFTypes.sv */
package JZJCoreFTypes;

typedef enum logic [6:0]
{
	OPCODE_LOAD = 7'b0000011,
	OPCODE_STORE = 7'b0100011,
	OPCODE_OP = 7'b0110011,
	OPCODE_OP_IMM = 7'b0010011,
	OPCODE_LUI = 7'b0110111,
	OPCODE_AUIPC = 7'b0010111,
	OPCODE_JAL = 7'b1101111,
	OPCODE_JALR = 7'b1100111,
	OPCODE_BRANCH = 7'b1100011,
	OPCODE_SYSTEM = 7'b1110011
} Opcode_t;

//One fetched word, viewed in each RV32I encoding format
typedef union packed
{
	struct packed {logic [6:0] funct7; logic [4:0] rs2, rs1; logic [2:0] funct3; logic [4:0] rd;
		Opcode_t opcode;} R;
	struct packed {logic [11:0] imm11_0; logic [4:0] rs1; logic [2:0] funct3; logic [4:0] rd;
		Opcode_t opcode;} I;
	struct packed {logic [6:0] imm11_5; logic [4:0] rs2, rs1; logic [2:0] funct3;
		logic [4:0] imm4_0; Opcode_t opcode;} S;
	struct packed {logic imm12; logic [5:0] imm10_5; logic [4:0] rs2, rs1; logic [2:0] funct3;
		logic [3:0] imm4_1; logic imm11; Opcode_t opcode;} B;
	struct packed {logic [19:0] imm31_12; logic [4:0] rd; Opcode_t opcode;} U;
	struct packed {logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
		logic [4:0] rd; Opcode_t opcode;} J;
} Instruction_t;

typedef enum logic [1:0] {NOP, LOAD, STORE} MemoryMode_t;

typedef enum logic [1:0] {CURRENT_PC, NEXT_PC_SEQUENTIAL, BRANCH_TARGET, JALR_TARGET}
	InstructionAddressSource_t;

typedef enum logic [2:0] {I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE} ImmediateFormerMode_t;

typedef enum logic [1:0] {ALU_RESULT, MEMORY_DATA, IMMEDIATE_VALUE, RETURN_ADDRESS} RdSource_t;

//Why the core stopped
typedef enum logic [2:0]
{
	NONE,
	STOP,//ecall or ebreak
	BAD_OPCODE,
	BAD_BRANCH_FUNCT3,
	BAD_MEMORY_FUNCT3,
	PC_MISALIGNED,
	UNALIGNED_ACCESS
} HaltReason_t;

endpackage

/* hw/FetchUnit.sv */
`timescale 1ns/1ps
`include "JZJCoreF_defs.svh"

module FetchUnit import JZJCoreFTypes::*;
(
	input clock, reset,
	input programCounterWriteEnable,
	input InstructionAddressSource_t instructionAddressSource,
	input branchTaken,
	input [31:0] branchTarget,
	input [31:0] jalrTarget,
	output logic [31:0] instructionAddress,
	output logic [31:0] programCounter,
	output logic programCounterMisaligned
);

logic [31:0] sequentialAddress;
assign sequentialAddress = programCounter + 32'd4;

//Address sent to memory doubles as the next PC
always_comb
begin
	unique case (instructionAddressSource)
		CURRENT_PC: instructionAddress = programCounter;//Refetch, used while waiting on a load
		NEXT_PC_SEQUENTIAL: instructionAddress = sequentialAddress;
		BRANCH_TARGET: instructionAddress = branchTaken ? branchTarget : sequentialAddress;
		JALR_TARGET: instructionAddress = jalrTarget;
	endcase
end

always_ff @(posedge clock)
begin
	if (reset)
		programCounter <= `RESET_PC;
	else if (programCounterWriteEnable)
		programCounter <= instructionAddress;
end

assign programCounterMisaligned = instructionAddress[1:0] != 2'b00;//Word fetches only

endmodule

/* hw/ControlLogic.sv */
`timescale 1ns/1ps

module ControlLogic import JZJCoreFTypes::*;
(
	input clock, reset,
	input Instruction_t instruction,
	output logic rdWriteEnable,
	output RdSource_t rdSource,
	output MemoryMode_t memoryMode,
	output logic programCounterWriteEnable,
	output InstructionAddressSource_t instructionAddressSource,
	output logic opImm,
	output ImmediateFormerMode_t immediateFormerMode,
	output logic halted,
	output HaltReason_t haltReason,
	input branchBadFunct3,
	input programCounterMisaligned,
	input memoryUnalignedAccess,
	input memoryBadFunct3
);

typedef enum logic [2:0] {INITIAL_WAIT, INITIAL_FETCH, FETCH_EXECUTE, EXECUTE, HALT} State_t;
State_t currentState, nextState;

logic stop;//ecall/ebreak seen
logic controlError;//Undecodable instruction
logic decodeWrite;//Decoder wants rd written
logic twoCycle;//LW needs an EXECUTE cycle for read data
logic activeState;
logic halt;
HaltReason_t nextReason;

assign activeState = (currentState == FETCH_EXECUTE) || (currentState == EXECUTE);

//Decoder
always_comb
begin
	decodeWrite = 1'b0;
	rdSource = ALU_RESULT;
	memoryMode = NOP;
	instructionAddressSource = NEXT_PC_SEQUENTIAL;
	opImm = 1'b0;
	immediateFormerMode = I_TYPE;//Default also covers loads and jalr
	stop = 1'b0;
	controlError = 1'b0;
	twoCycle = 1'b0;
	unique case (currentState)
		INITIAL_WAIT, INITIAL_FETCH, HALT: instructionAddressSource = CURRENT_PC;
		EXECUTE:
		begin
			decodeWrite = 1'b1;//Second half of LW
			rdSource = MEMORY_DATA;
		end
		FETCH_EXECUTE:
		begin
			unique case (instruction.R.opcode)
				OPCODE_OP: decodeWrite = 1'b1;
				OPCODE_OP_IMM:
				begin
					decodeWrite = 1'b1;
					opImm = 1'b1;
				end
				OPCODE_LUI, OPCODE_AUIPC:
				begin
					decodeWrite = 1'b1;
					rdSource = IMMEDIATE_VALUE;
					immediateFormerMode = U_TYPE;
				end
				OPCODE_JAL:
				begin
					decodeWrite = 1'b1;
					rdSource = RETURN_ADDRESS;
					immediateFormerMode = J_TYPE;
					instructionAddressSource = BRANCH_TARGET;//Always taken
				end
				OPCODE_JALR:
				begin
					decodeWrite = 1'b1;
					rdSource = RETURN_ADDRESS;
					instructionAddressSource = JALR_TARGET;
					controlError = instruction.R.funct3 != 3'b000;
				end
				OPCODE_BRANCH:
				begin
					immediateFormerMode = B_TYPE;
					instructionAddressSource = BRANCH_TARGET;
				end
				OPCODE_LOAD:
				begin
					memoryMode = LOAD;
					instructionAddressSource = CURRENT_PC;//Hold fetch until data returns
					twoCycle = 1'b1;
				end
				OPCODE_STORE:
				begin
					memoryMode = STORE;
					immediateFormerMode = S_TYPE;
				end
				OPCODE_SYSTEM:
				begin
					stop = instruction.R.funct3 == 3'b000;//ecall and ebreak
					controlError = instruction.R.funct3 != 3'b000;//No CSRs
				end
				default: controlError = 1'b1;
			endcase
		end
		default: instructionAddressSource = CURRENT_PC;
	endcase
end

//First cause wins
always_comb
begin
	nextReason = NONE;
	if (activeState)
	begin
		if (stop)
			nextReason = STOP;
		else if (controlError)
			nextReason = BAD_OPCODE;
		else if (branchBadFunct3)
			nextReason = BAD_BRANCH_FUNCT3;
		else if (programCounterMisaligned)
			nextReason = PC_MISALIGNED;
		else if (memoryUnalignedAccess)
			nextReason = UNALIGNED_ACCESS;
		else if (memoryBadFunct3)
			nextReason = BAD_MEMORY_FUNCT3;
	end
end
assign halt = nextReason != NONE;

//Faulting instruction leaves no trace in rd or PC
assign rdWriteEnable = decodeWrite && !halt;
assign programCounterWriteEnable = !halt &&
	(((currentState == FETCH_EXECUTE) && !twoCycle) || (currentState == EXECUTE));

always_comb
begin
	if (halt)
		nextState = HALT;
	else
	begin
		unique case (currentState)
			INITIAL_WAIT: nextState = INITIAL_FETCH;
			INITIAL_FETCH: nextState = FETCH_EXECUTE;//First word is in memory's output reg now
			FETCH_EXECUTE: nextState = twoCycle ? EXECUTE : FETCH_EXECUTE;
			EXECUTE: nextState = FETCH_EXECUTE;
			default: nextState = HALT;//Also spins in HALT
		endcase
	end
end

always_ff @(posedge clock)
begin
	if (reset)
	begin
		currentState <= INITIAL_WAIT;
		haltReason <= NONE;
	end
	else
	begin
		currentState <= nextState;
		if (halt)
			haltReason <= nextReason;//Only reachable once; HALT is not an active state
	end
end

assign halted = currentState == HALT;

//Held PC refetches the LW for its EXECUTE cycle
assert property (@(posedge clock) disable iff (reset)
	(currentState == EXECUTE) |-> (instruction.R.opcode == OPCODE_LOAD));

//Sticky halt with a frozen reason
assert property (@(posedge clock) disable iff (reset) halted |=> halted && $stable(haltReason));

endmodule

/* hw/RegisterFile.sv */
`timescale 1ns/1ps
`include "JZJCoreF_defs.svh"

module RegisterFile
(
	input clock,
	input [4:0] rs1Address,
	input [4:0] rs2Address,
	input [4:0] rdAddress,
	input rdWriteEnable,
	input [31:0] rdData,
	input [4:0] debugAddress,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data,
	output logic [31:0] debugData
);

logic [31:0] registers [1:`REGISTER_COUNT - 1];//x0 has no storage

always_ff @(posedge clock)
begin
	if (rdWriteEnable && (rdAddress != 5'd0))
		registers[rdAddress] <= rdData;
end

//Asynchronous reads, x0 hardwired
assign rs1Data = (rs1Address == 5'd0) ? 32'd0 : registers[rs1Address];
assign rs2Data = (rs2Address == 5'd0) ? 32'd0 : registers[rs2Address];
assign debugData = (debugAddress == 5'd0) ? 32'd0 : registers[debugAddress];

endmodule

/* hw/ExecuteUnit.sv */
`timescale 1ns/1ps

module ExecuteUnit import JZJCoreFTypes::*;
(
	input Instruction_t instruction,
	input [31:0] programCounter,
	input [31:0] rs1Data,
	input [31:0] rs2Data,
	input [31:0] loadData,
	input opImm,
	input ImmediateFormerMode_t immediateFormerMode,
	input RdSource_t rdSource,
	output logic [31:0] rdData,
	output logic branchTaken,
	output logic [31:0] branchTarget,
	output logic [31:0] jalrTarget,
	output logic [31:0] dataAddress,
	output logic [31:0] storeData,
	output logic branchBadFunct3
);

logic [31:0] immediate;
logic [31:0] operandB;
logic [4:0] shiftAmount;
logic subtract;
logic [31:0] aluResult;
logic [31:0] upperValue;//LUI or AUIPC result
logic [31:0] jalrSum;
logic condition;

//Immediate former
always_comb
begin
	case (immediateFormerMode)
		I_TYPE: immediate = {{20{instruction.I.imm11_0[11]}}, instruction.I.imm11_0};
		S_TYPE: immediate = {{20{instruction.S.imm11_5[6]}}, instruction.S.imm11_5,
			instruction.S.imm4_0};
		B_TYPE: immediate = {{19{instruction.B.imm12}}, instruction.B.imm12, instruction.B.imm11,
			instruction.B.imm10_5, instruction.B.imm4_1, 1'b0};
		U_TYPE: immediate = {instruction.U.imm31_12, 12'h000};
		J_TYPE: immediate = {{11{instruction.J.imm20}}, instruction.J.imm20, instruction.J.imm19_12,
			instruction.J.imm11, instruction.J.imm10_1, 1'b0};
		default: immediate = 32'd0;
	endcase
end

//ALU
assign operandB = opImm ? immediate : rs2Data;
assign shiftAmount = operandB[4:0];
assign subtract = !opImm && instruction.R.funct7[5];//No subi in RV32I

always_comb
begin
	case (instruction.R.funct3)
		3'b000: aluResult = subtract ? rs1Data - operandB : rs1Data + operandB;
		3'b001: aluResult = rs1Data << shiftAmount;
		3'b010: aluResult = {31'd0, $signed(rs1Data) < $signed(operandB)};
		3'b011: aluResult = {31'd0, rs1Data < operandB};
		3'b100: aluResult = rs1Data ^ operandB;
		3'b101: aluResult = instruction.R.funct7[5] ? 32'($signed(rs1Data) >>> shiftAmount)
			: rs1Data >> shiftAmount;//Same bit for srai and sra
		3'b110: aluResult = rs1Data | operandB;
		default: aluResult = rs1Data & operandB;
	endcase
end

//Branch ALU
always_comb
begin
	branchBadFunct3 = 1'b0;
	case (instruction.B.funct3)
		3'b000: condition = rs1Data == rs2Data;
		3'b001: condition = rs1Data != rs2Data;
		3'b100: condition = $signed(rs1Data) < $signed(rs2Data);
		3'b101: condition = $signed(rs1Data) >= $signed(rs2Data);
		3'b110: condition = rs1Data < rs2Data;
		3'b111: condition = rs1Data >= rs2Data;
		default:
		begin
			condition = 1'b0;
			branchBadFunct3 = instruction.B.opcode == OPCODE_BRANCH;//Only a fault on branches
		end
	endcase
end

assign branchTaken = (instruction.J.opcode == OPCODE_JAL) ||
	((instruction.B.opcode == OPCODE_BRANCH) && condition);
assign branchTarget = programCounter + immediate;//B or J immediate
assign jalrSum = rs1Data + immediate;
assign jalrTarget = {jalrSum[31:1], 1'b0};

assign dataAddress = rs1Data + immediate;
assign storeData = rs2Data;

assign upperValue = (instruction.U.opcode == OPCODE_AUIPC) ? programCounter + immediate
	: immediate;

//rd chooser
always_comb
begin
	unique case (rdSource)
		ALU_RESULT: rdData = aluResult;
		MEMORY_DATA: rdData = loadData;
		IMMEDIATE_VALUE: rdData = upperValue;
		RETURN_ADDRESS: rdData = programCounter + 32'd4;//Link for jal/jalr
	endcase
end

endmodule

/* hw/MemoryController.sv */
`timescale 1ns/1ps
`include "JZJCoreF_defs.svh"

module MemoryController import JZJCoreFTypes::*;
(
	input clock, reset,
	input [31:0] instructionAddress,
	input MemoryMode_t memoryMode,
	input [2:0] funct3,
	input [31:0] dataAddress,
	input [31:0] storeData,
	input loadEnable,
	input [11:0] loadAddress,
	input [31:0] loadData,
	output Instruction_t instruction,
	output logic [31:0] readData,
	output logic memoryUnalignedAccess,
	output logic memoryBadFunct3
);

localparam ADDRESS_BITS = $clog2(`MEMORY_WORDS);

logic [31:0] memory [0:`MEMORY_WORDS - 1];
logic [ADDRESS_BITS - 1:0] instructionIndex;
logic [ADDRESS_BITS - 1:0] dataIndex;
logic storeEnable;

//Byte addresses in, word index out
assign instructionIndex = instructionAddress[ADDRESS_BITS + 1:2];
assign dataIndex = dataAddress[ADDRESS_BITS + 1:2];

assign memoryBadFunct3 = (memoryMode != NOP) && (funct3 != 3'b010);//lw/sw only
assign memoryUnalignedAccess = (memoryMode != NOP) && (dataAddress[1:0] != 2'b00);
assign storeEnable = (memoryMode == STORE) && !memoryBadFunct3 && !memoryUnalignedAccess;

always_ff @(posedge clock)
begin
	if (loadEnable)
		memory[loadAddress] <= loadData;//Program load during reset
	else if (storeEnable)
		memory[dataIndex] <= storeData;
end

//Both read ports are registered
always_ff @(posedge clock)
begin
	instruction <= memory[instructionIndex];
	readData <= memory[dataIndex];
end

assert property (@(posedge clock) loadEnable |-> reset);

endmodule

/* hw/JZJCoreF.sv */
`timescale 1ns/1ps

module JZJCoreF import JZJCoreFTypes::*;
(
	input clock, reset,
	input loadEnable,
	input [11:0] loadAddress,
	input [31:0] loadData,
	input [4:0] debugAddress,
	output logic [31:0] debugData,
	output logic halted,
	output HaltReason_t haltReason
);

Instruction_t instruction;
logic [31:0] instructionAddress, programCounter;
logic [31:0] rs1Data, rs2Data, rdData;
logic [31:0] branchTarget, jalrTarget, dataAddress, storeData;
logic [31:0] memoryReadData;//Not the program load data
logic rdWriteEnable, programCounterWriteEnable, opImm, branchTaken;
logic branchBadFunct3, programCounterMisaligned, memoryUnalignedAccess, memoryBadFunct3;
RdSource_t rdSource;
MemoryMode_t memoryMode;
InstructionAddressSource_t instructionAddressSource;
ImmediateFormerMode_t immediateFormerMode;

FetchUnit i_FetchUnit (.clock, .reset, .programCounterWriteEnable, .instructionAddressSource,
	.branchTaken, .branchTarget, .jalrTarget, .instructionAddress, .programCounter,
	.programCounterMisaligned);

ControlLogic i_ControlLogic (.clock, .reset, .instruction, .rdWriteEnable, .rdSource,
	.memoryMode, .programCounterWriteEnable, .instructionAddressSource, .opImm,
	.immediateFormerMode, .halted, .haltReason, .branchBadFunct3, .programCounterMisaligned,
	.memoryUnalignedAccess, .memoryBadFunct3);

RegisterFile i_RegisterFile (.clock, .rs1Address(instruction.R.rs1),
	.rs2Address(instruction.R.rs2), .rdAddress(instruction.R.rd), .rdWriteEnable, .rdData,
	.debugAddress, .rs1Data, .rs2Data, .debugData);

ExecuteUnit i_ExecuteUnit (.instruction, .programCounter, .rs1Data, .rs2Data,
	.loadData(memoryReadData), .opImm, .immediateFormerMode, .rdSource, .rdData, .branchTaken,
	.branchTarget, .jalrTarget, .dataAddress, .storeData, .branchBadFunct3);

MemoryController i_MemoryController (.clock, .reset, .instructionAddress, .memoryMode,
	.funct3(instruction.R.funct3), .dataAddress, .storeData, .loadEnable, .loadAddress,
	.loadData, .instruction, .readData(memoryReadData), .memoryUnalignedAccess,
	.memoryBadFunct3);

endmodule

/* tests/JZJCoreFTb.sv */
`timescale 1ns/1ps

module JZJCoreFTb import JZJCoreFTypes::*; ();

localparam int runCount = 20;//Programs loaded over all six tests
localparam int runCycles = 16 + 32 + 64;//Reset, load and execute, worst case per program
localparam int cycleLimit = runCount * runCycles + 20;//Plus the sticky halt wait

logic clock, reset, loadEnable;
logic [11:0] loadAddress;
logic [31:0] loadData;
logic [4:0] debugAddress;
logic [31:0] debugData;
logic halted;
HaltReason_t haltReason;

logic [31:0] programWords [$];//Image for the next run, word 0 at address 0
int errorCount;
int errorsBefore;//Error count when the current test started
int cycleCount;
int seed;

JZJCoreF i_JZJCoreF (.clock, .reset, .loadEnable, .loadAddress, .loadData, .debugAddress,
	.debugData, .halted, .haltReason);

always #50 clock = ~clock;

//Watchdog
always @(posedge clock)
begin
	cycleCount <= cycleCount + 1;
	if (cycleCount >= cycleLimit)
	begin
		$display("Timeout: core never halted within %0d cycles", cycleLimit);
		$display("Testbench failed");
		$finish;
	end
end

//Instruction encoders, all through the union views
function automatic logic [31:0] encodeR(int funct7, int rs2, int rs1, int funct3, int rd);
	Instruction_t word;
	word.R = '{funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], OPCODE_OP};
	return word;
endfunction

function automatic logic [31:0] encodeI(int imm, int rs1, int funct3, int rd, Opcode_t opcode);
	Instruction_t word;
	word.I = '{imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode};
	return word;
endfunction

function automatic logic [31:0] encodeS(int imm, int rs2, int rs1);
	Instruction_t word;
	word.S = '{imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPCODE_STORE};//sw only
	return word;
endfunction

function automatic logic [31:0] encodeB(int imm, int rs2, int rs1, int funct3);
	Instruction_t word;
	word.B = '{imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
		OPCODE_BRANCH};
	return word;
endfunction

function automatic logic [31:0] encodeU(int imm20, int rd, Opcode_t opcode);
	Instruction_t word;
	word.U = '{imm20[19:0], rd[4:0], opcode};
	return word;
endfunction

function automatic logic [31:0] encodeJ(int imm, int rd);
	Instruction_t word;
	word.J = '{imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPCODE_JAL};
	return word;
endfunction

function automatic logic [31:0] addi(int rd, int rs1, int imm);
	return encodeI(imm, rs1, 0, rd, OPCODE_OP_IMM);
endfunction

function automatic logic [31:0] lw(int rd, int rs1, int imm);
	return encodeI(imm, rs1, 2, rd, OPCODE_LOAD);
endfunction

function automatic logic [31:0] ecall();
	return encodeI(0, 0, 0, 0, OPCODE_SYSTEM);
endfunction

task automatic compareWord(input logic [31:0] actual, input logic [31:0] expected,
	input string name);
	if (actual !== expected)
	begin
		$display("Mismatch %s: got %h expected %h", name, actual, expected);
		errorCount++;
	end
endtask

task automatic compareHaltReason(input HaltReason_t actual, input HaltReason_t expected);
	if (actual !== expected)
	begin
		$display("Mismatch haltReason: got %h expected %h", actual, expected);
		errorCount++;
	end
endtask

task automatic checkRegister(input int index, input logic [31:0] expected);
	debugAddress = index[4:0];
	#1;//Debug port is combinational
	compareWord(debugData, expected, $sformatf("x%0d", index));
endtask

//Hold reset at least 16 cycles, loading one word per cycle meanwhile
task automatic resetAndLoad();
	int cycles;
	cycles = (programWords.size() > 16) ? programWords.size() : 16;
	@(posedge clock);
	#1;
	reset = 1'b1;
	for (int i = 0; i < cycles; i++)
	begin
		loadEnable = i < programWords.size();
		loadAddress = i[11:0];
		loadData = (i < programWords.size()) ? programWords[i] : 32'd0;
		@(posedge clock);
		#1;
	end
	loadEnable = 1'b0;
	reset = 1'b0;
endtask

task automatic runUntilHalt();
	while (halted !== 1'b1)
	begin
		@(posedge clock);
		#1;
	end
endtask

task automatic runProgram();
	resetAndLoad();
	runUntilHalt();
	programWords.delete();
endtask

task automatic startTest();
	programWords.delete();
	errorsBefore = errorCount;
endtask

task automatic finishTest(input string name);
	if (errorCount == errorsBefore)
		$display("%s: ok", name);
	else
		$display("%s: %0d errors", name, errorCount - errorsBefore);
endtask

task automatic aluTest();
	logic [31:0] a, b;
	int auipcAt;
	startTest();
	a = 32'd100;
	b = 32'hFFFFFFF9;//-7
	programWords.push_back(addi(1, 0, 100));
	programWords.push_back(addi(2, 0, -7));
	programWords.push_back(encodeR(0, 2, 1, 0, 3));//add
	programWords.push_back(encodeR(32, 2, 1, 0, 4));//sub
	programWords.push_back(encodeR(0, 2, 1, 4, 5));//xor
	programWords.push_back(encodeR(0, 2, 1, 6, 6));//or
	programWords.push_back(encodeR(0, 2, 1, 7, 7));//and
	programWords.push_back(encodeI(3, 1, 1, 8, OPCODE_OP_IMM));//slli
	programWords.push_back(encodeI(32'h401, 2, 5, 9, OPCODE_OP_IMM));//srai
	programWords.push_back(encodeI(28, 2, 5, 10, OPCODE_OP_IMM));//srli
	programWords.push_back(encodeR(0, 1, 2, 2, 11));//slt x2 < x1
	programWords.push_back(encodeR(0, 1, 2, 3, 12));//sltu x2 < x1
	programWords.push_back(encodeU(32'hABCDE, 13, OPCODE_LUI));
	auipcAt = programWords.size() * 4;
	programWords.push_back(encodeU(1, 14, OPCODE_AUIPC));
	programWords.push_back(ecall());
	runProgram();
	compareHaltReason(haltReason, STOP);
	checkRegister(1, a);
	checkRegister(2, b);
	checkRegister(3, a + b);
	checkRegister(4, a - b);
	checkRegister(5, a ^ b);
	checkRegister(6, a | b);
	checkRegister(7, a & b);
	checkRegister(8, a << 3);
	checkRegister(9, $signed(b) >>> 1);//Sign bit refills
	checkRegister(10, b >> 28);
	checkRegister(11, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
	checkRegister(12, (b < a) ? 32'd1 : 32'd0);
	checkRegister(13, 32'hABCDE000);
	checkRegister(14, 32'h1000 + auipcAt);
	finishTest("ALU operations");
endtask

task automatic branchTest();
	int jalAt, jalrAt;
	startTest();
	programWords.push_back(addi(4, 0, 11));//Markers for skipped writes
	programWords.push_back(addi(7, 0, 22));
	programWords.push_back(addi(8, 0, 33));
	programWords.push_back(addi(1, 0, 5));//Loop counter
	programWords.push_back(addi(2, 0, 0));
	programWords.push_back(addi(2, 2, 1));//Loop body at 20
	programWords.push_back(addi(1, 1, -1));
	programWords.push_back(encodeB(-8, 0, 1, 1));//bne back to 20
	jalAt = programWords.size() * 4;
	programWords.push_back(encodeJ(12, 3));
	programWords.push_back(addi(4, 0, 99));
	programWords.push_back(addi(4, 0, 98));
	programWords.push_back(addi(5, 0, 60));//jalr target
	jalrAt = programWords.size() * 4;
	programWords.push_back(encodeI(0, 5, 0, 6, OPCODE_JALR));
	programWords.push_back(addi(7, 0, 77));
	programWords.push_back(addi(7, 0, 76));
	programWords.push_back(encodeB(8, 0, 0, 0));//beq taken, at 60
	programWords.push_back(addi(8, 0, 1));
	programWords.push_back(encodeB(8, 0, 2, 4));//blt not taken
	programWords.push_back(addi(9, 0, 44));
	programWords.push_back(ecall());
	runProgram();
	compareHaltReason(haltReason, STOP);
	checkRegister(1, 0);
	checkRegister(2, 5);
	checkRegister(3, jalAt + 4);
	checkRegister(6, jalrAt + 4);
	checkRegister(4, 11);
	checkRegister(7, 22);
	checkRegister(8, 33);
	checkRegister(9, 44);
	finishTest("Branches and jumps");
endtask

task automatic memoryTest();
	logic [31:0] first, second, third;
	startTest();
	first = 32'h123;
	second = 32'h12345678;
	third = 32'hFFFFFFFF;
	programWords.push_back(addi(1, 0, 32'h123));
	programWords.push_back(encodeU(32'h12345, 2, OPCODE_LUI));
	programWords.push_back(addi(2, 2, 32'h678));
	programWords.push_back(addi(3, 0, -1));
	programWords.push_back(addi(10, 0, 32'h400));//Data well past the code
	programWords.push_back(encodeS(0, 1, 10));
	programWords.push_back(encodeS(4, 2, 10));
	programWords.push_back(encodeS(12, 3, 10));
	programWords.push_back(lw(11, 10, 0));
	programWords.push_back(lw(12, 10, 4));
	programWords.push_back(lw(13, 10, 12));
	programWords.push_back(encodeR(0, 12, 11, 0, 14));//Uses both loads
	programWords.push_back(encodeR(0, 14, 13, 0, 15));
	programWords.push_back(ecall());
	runProgram();
	compareHaltReason(haltReason, STOP);
	checkRegister(11, first);
	checkRegister(12, second);
	checkRegister(13, third);
	checkRegister(14, first + second);
	checkRegister(15, third + first + second);
	finishTest("Load and store");
endtask

task automatic errorTest();
	startTest();
	programWords.push_back(addi(20, 0, 32'h55));
	programWords.push_back(32'h0000007F);//Undefined opcode
	programWords.push_back(ecall());
	runProgram();
	compareHaltReason(haltReason, BAD_OPCODE);
	checkRegister(20, 32'h55);
	programWords.push_back(addi(21, 0, 32'h66));
	programWords.push_back(addi(22, 0, 32'h77));
	programWords.push_back(addi(10, 0, 32'h402));
	programWords.push_back(lw(22, 10, 0));//Address ends in 2
	programWords.push_back(ecall());
	runProgram();
	compareHaltReason(haltReason, UNALIGNED_ACCESS);
	checkRegister(21, 32'h66);
	checkRegister(22, 32'h77);
	programWords.push_back(addi(23, 0, 32'h88));
	programWords.push_back(addi(24, 0, 32'h99));
	programWords.push_back(addi(10, 0, 32'h102));
	programWords.push_back(encodeI(0, 10, 0, 24, OPCODE_JALR));//Lands on 0x102
	programWords.push_back(ecall());
	runProgram();
	compareHaltReason(haltReason, PC_MISALIGNED);
	checkRegister(23, 32'h88);
	checkRegister(24, 32'h99);//Link suppressed
	programWords.push_back(addi(25, 0, 32'h31));
	programWords.push_back(encodeB(8, 0, 0, 2));//No branch uses funct3 2
	programWords.push_back(ecall());
	runProgram();
	compareHaltReason(haltReason, BAD_BRANCH_FUNCT3);
	checkRegister(25, 32'h31);
	finishTest("Error halts");
endtask

task automatic randomTest();
	logic [31:0] randomWord;
	int immA, immB, immC;
	logic [31:0] sum, mixed, total;
	startTest();
	for (int run = 0; run < 12; run++)
	begin
		randomWord = $random(seed);
		immA = {{20{randomWord[11]}}, randomWord[11:0]};//Sign extended like the core
		immB = {{20{randomWord[23]}}, randomWord[23:12]};
		randomWord = $random(seed);
		immC = {{20{randomWord[11]}}, randomWord[11:0]};
		sum = immA;
		mixed = sum ^ immB;
		total = mixed + immC;
		programWords.push_back(addi(1, 0, immA));
		programWords.push_back(encodeI(immB, 1, 4, 2, OPCODE_OP_IMM));//xori
		programWords.push_back(addi(3, 2, immC));
		programWords.push_back(ecall());
		runProgram();
		compareHaltReason(haltReason, STOP);
		checkRegister(1, sum);
		checkRegister(2, mixed);
		checkRegister(3, total);
	end
	finishTest("Random immediates");
endtask

task automatic stickyHaltTest();
	startTest();
	programWords.push_back(addi(16, 0, 32'h10));
	programWords.push_back(encodeI(1, 0, 0, 0, OPCODE_SYSTEM));//ebreak
	programWords.push_back(addi(16, 0, 32'h20));
	programWords.push_back(ecall());
	runProgram();
	repeat (20)
	begin
		@(posedge clock);
		#1;
		if (halted !== 1'b1)
		begin
			$display("Core left the halted state after EBREAK");
			errorCount++;
		end
	end
	compareHaltReason(haltReason, STOP);
	checkRegister(16, 32'h10);
	finishTest("Halt is sticky");
endtask

initial
begin
	clock = 1'b0;
	reset = 1'b1;
	loadEnable = 1'b0;
	loadAddress = 12'd0;
	loadData = 32'd0;
	debugAddress = 5'd0;
	errorCount = 0;
	errorsBefore = 0;
	cycleCount = 0;
	seed = 94;
	aluTest();
	branchTest();
	memoryTest();
	errorTest();
	randomTest();
	stickyHaltTest();
	$display("6 tests run, %0d errors", errorCount);
	if (errorCount == 0)
		$display("Testbench passed");
	else
		$display("Testbench failed");
	$finish;
end

endmodule

/* files.f */
+incdir+hw
hw/JZJCoreFTypes.sv
hw/FetchUnit.sv
hw/ControlLogic.sv
hw/RegisterFile.sv
hw/ExecuteUnit.sv
hw/MemoryController.sv
hw/JZJCoreF.sv
tests/JZJCoreFTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = JZJCoreFTb
FILELIST = files.f
BUILD = obj_dir
BIN = $(BUILD)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD)
